/* source/tmd_pkg.sv */
`default_nettype none

package tmd_pkg;

  localparam int unsigned ADDR_W       = 8;
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned FIFO_DEPTH_W = 4;
  localparam int unsigned COUNT_W      = 24;
  localparam int unsigned RAM_WORDS    = 2 ** ADDR_W;
  localparam int unsigned FIFO_WORDS   = 2 ** FIFO_DEPTH_W;

  // One RAM write port
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ram_wr_t;

  // Streaming transfer command
  typedef struct packed {
    logic               enable;
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] count;
    logic               inc;
    logic               dec;
    logic               flush;
  } xfer_cmd_t;

  // Expected successor in the test pattern with wrap at the RAM size
  function automatic logic [DATA_W-1:0] seq_next(input logic [DATA_W-1:0] value);
    return (value == DATA_W'(RAM_WORDS - 1)) ? '0 : value + 1'b1;
  endfunction

endpackage

`default_nettype wire

/* source/pingpong_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pingpong_fifo
  import tmd_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  output logic [1:0]              wr_ready,
  input  wire logic [1:0]         wr_activate,
  output logic [COUNT_W-1:0]      wr_size,
  input  wire logic               wr_strobe,
  input  wire logic [DATA_W-1:0]  wr_data,
  output logic                    rd_ready,
  input  wire logic               rd_activate,
  output logic [COUNT_W-1:0]      rd_count,
  output logic [DATA_W-1:0]       rd_data,
  input  wire logic               rd_strobe,
  output logic                    empty
);

  logic [DATA_W-1:0]       bank_mem [2][FIFO_WORDS];
  logic [FIFO_DEPTH_W:0]   fill_cnt [2];
  logic [1:0]              bank_used;
  logic [1:0]              committed;
  logic [1:0]              wr_act_q;
  logic                    rd_act_q;
  logic                    head;
  logic [FIFO_DEPTH_W-1:0] rd_ptr;
  logic                    wr_bank;
  logic                    wr_push;
  logic [1:0]              commit;
  logic                    release_bank;

  assign wr_bank      = wr_activate[1];
  assign wr_push      = (|wr_activate) && wr_strobe && !fill_cnt[wr_bank][FIFO_DEPTH_W];
  // Falling activate edges
  assign commit       = wr_act_q & ~wr_activate;
  assign release_bank = rd_act_q & ~rd_activate;

  // No bank is offered while held in reset
  assign wr_ready = rst ? 2'b00 : ~bank_used;
  assign wr_size  = COUNT_W'(FIFO_WORDS);
  assign rd_ready = committed[head] && !rd_act_q;
  assign rd_count = COUNT_W'(fill_cnt[head]);
  // Show-ahead head word
  assign rd_data  = bank_mem[head][rd_ptr];
  assign empty    = !(|bank_used) && !(|wr_activate);

  always_ff @(posedge clk) begin
    if (rst) begin
      bank_used   <= '0;
      committed   <= '0;
      wr_act_q    <= '0;
      rd_act_q    <= 1'b0;
      head        <= 1'b0;
      rd_ptr      <= '0;
      fill_cnt[0] <= '0;
      fill_cnt[1] <= '0;
    end else begin
      wr_act_q <= wr_activate;
      rd_act_q <= rd_activate;
      for (int i = 0; i < 2; i++) begin
        if (wr_activate[i]) begin
          bank_used[i] <= 1'b1;
        end
        // First committed bank becomes the head
        if (commit[i]) begin
          committed[i] <= 1'b1;
          if (!committed[1-i]) begin
            head <= 1'(i);
          end
        end
      end
      if (wr_push) begin
        fill_cnt[wr_bank] <= fill_cnt[wr_bank] + 1'b1;
      end
      if (rd_activate && rd_strobe) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (release_bank) begin
        bank_used[head] <= 1'b0;
        committed[head] <= 1'b0;
        fill_cnt[head]  <= '0;
        rd_ptr          <= '0;
        head            <= ~head;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_push) begin
      bank_mem[wr_bank][fill_cnt[wr_bank][FIFO_DEPTH_W-1:0]] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* source/pattern_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_ram
  import tmd_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire ram_wr_t           eng_wr,
  input  wire logic [ADDR_W-1:0] eng_rd_addr,
  input  wire logic              bram_en,
  input  wire logic              bram_we,
  input  wire logic [ADDR_W-1:0] bram_address,
  input  wire logic [DATA_W-1:0] bram_data_in,
  output logic [DATA_W-1:0]      rd_data,
  output logic                   initializing
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [ADDR_W-1:0] fill_addr;
  logic              fill_active;
  ram_wr_t           wr;
  logic [ADDR_W-1:0] rd_addr;

  assign initializing = fill_active;

  // Fill first, then host over engines
  always_comb begin
    if (fill_active) begin
      wr      = '{en: 1'b1, addr: fill_addr, data: DATA_W'(fill_addr)};
      rd_addr = eng_rd_addr;
    end else if (bram_en) begin
      wr      = '{en: bram_we, addr: bram_address, data: bram_data_in};
      rd_addr = bram_address;
    end else begin
      wr      = eng_wr;
      rd_addr = eng_rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_active <= 1'b1;
      fill_addr   <= '0;
    end else if (fill_active) begin
      fill_addr <= fill_addr + 1'b1;
      if (fill_addr == ADDR_W'(RAM_WORDS - 1)) begin
        fill_active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* source/stream_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_writer
  import tmd_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire xfer_cmd_t          cmd,
  input  wire logic               initializing,
  input  wire logic               fifo_ready,
  output logic                    fifo_activate,
  input  wire logic [COUNT_W-1:0] fifo_count,
  input  wire logic [DATA_W-1:0]  fifo_data,
  output logic                    fifo_strobe,
  input  wire logic               fifo_empty,
  output ram_wr_t                 ram_wr,
  output logic                    finished,
  output logic                    seq_error
);

  logic               act;
  logic               en_q;
  logic               pop;
  logic [COUNT_W-1:0] pop_cnt;
  logic [COUNT_W-1:0] word_cnt;
  logic [ADDR_W-1:0]  wr_addr;
  logic [DATA_W-1:0]  prev_data;
  logic               have_prev;

  // One word per cycle straight from the show-ahead head into RAM
  assign pop           = act && (pop_cnt < fifo_count);
  assign fifo_activate = act;
  assign fifo_strobe   = pop;
  assign ram_wr        = '{en: pop, addr: wr_addr, data: fifo_data};
  assign finished      = (cmd.count != '0) && (word_cnt >= cmd.count) && fifo_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      act       <= 1'b0;
      en_q      <= 1'b0;
      pop_cnt   <= '0;
      word_cnt  <= '0;
      wr_addr   <= '0;
      have_prev <= 1'b0;
      seq_error <= 1'b0;
    end else begin
      en_q      <= cmd.enable;
      seq_error <= 1'b0;

      if (!act && fifo_ready && !initializing) begin
        act     <= 1'b1;
        pop_cnt <= '0;
      end else if (act && (pop_cnt >= fifo_count)) begin
        act <= 1'b0;
      end

      if (pop) begin
        pop_cnt   <= pop_cnt + 1'b1;
        word_cnt  <= word_cnt + 1'b1;
        have_prev <= 1'b1;
        if (cmd.inc) begin
          wr_addr <= wr_addr + 1'b1;
        end else if (cmd.dec) begin
          wr_addr <= wr_addr - 1'b1;
        end
        if (have_prev && !cmd.flush && (fifo_data != seq_next(prev_data))) begin
          seq_error <= 1'b1;
        end
      end

      // New command restarts address, count and check history
      if (cmd.enable && !en_q) begin
        wr_addr   <= cmd.addr;
        word_cnt  <= '0;
        have_prev <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      prev_data <= fifo_data;
    end
  end

endmodule

`default_nettype wire

/* source/stream_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_reader
  import tmd_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire xfer_cmd_t          cmd,
  input  wire logic               initializing,
  input  wire logic [1:0]         fifo_ready,
  output logic [1:0]              fifo_activate,
  input  wire logic [COUNT_W-1:0] fifo_size,
  output logic                    fifo_strobe,
  output logic [ADDR_W-1:0]       ram_rd_addr,
  input  wire logic [DATA_W-1:0]  ram_rd_data,
  output logic                    seq_error
);

  logic [1:0]         act;
  logic               en_q;
  logic               pending;
  logic               issue;
  logic               strobe_q;
  logic [COUNT_W-1:0] total;
  logic [COUNT_W-1:0] issued;
  logic [COUNT_W-1:0] bank_cnt;
  logic [ADDR_W-1:0]  rd_addr;
  logic [DATA_W-1:0]  prev_data;
  logic               have_prev;

  assign pending       = cmd.enable && !initializing && (issued < total);
  assign issue         = pending && (|act) && (bank_cnt < fifo_size);
  assign fifo_activate = act;
  // RAM data arrives one cycle after the address
  assign fifo_strobe   = strobe_q;
  assign ram_rd_addr   = rd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      act       <= '0;
      en_q      <= 1'b0;
      strobe_q  <= 1'b0;
      total     <= '0;
      issued    <= '0;
      bank_cnt  <= '0;
      rd_addr   <= '0;
      have_prev <= 1'b0;
      seq_error <= 1'b0;
    end else begin
      en_q      <= cmd.enable;
      strobe_q  <= issue;
      seq_error <= 1'b0;

      // Lower ready bank first
      if ((act == 2'b00) && (fifo_ready != 2'b00) && pending) begin
        act      <= fifo_ready[0] ? 2'b01 : 2'b10;
        bank_cnt <= '0;
      end

      if (issue) begin
        bank_cnt <= bank_cnt + 1'b1;
        issued   <= issued + 1'b1;
        if (cmd.inc) begin
          rd_addr <= rd_addr + 1'b1;
        end else if (cmd.dec) begin
          rd_addr <= rd_addr - 1'b1;
        end
      end

      // Commit once the last word has landed
      if ((|act) && !issue && !strobe_q &&
          ((bank_cnt >= fifo_size) || (issued >= total) || !cmd.enable)) begin
        act <= '0;
      end

      if (strobe_q) begin
        have_prev <= 1'b1;
        if (have_prev && !cmd.flush && (ram_rd_data != seq_next(prev_data))) begin
          seq_error <= 1'b1;
        end
      end

      if (cmd.enable && !en_q) begin
        rd_addr   <= cmd.addr;
        total     <= cmd.count;
        issued    <= '0;
        have_prev <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (strobe_q) begin
      prev_data <= ram_rd_data;
    end
  end

endmodule

`default_nettype wire

/* source/test_mem_dev.sv */
`timescale 1ns/1ps
`default_nettype none

module test_mem_dev
  import tmd_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               bram_en,
  input  wire logic               bram_we,
  input  wire logic [ADDR_W-1:0]  bram_address,
  input  wire logic [DATA_W-1:0]  bram_data_in,
  output logic [DATA_W-1:0]       bram_data_out,
  output logic                    initializing,
  input  wire xfer_cmd_t          wr_cmd,
  output logic                    write_finished,
  output logic                    write_error,
  output logic [1:0]              write_ready,
  input  wire logic [1:0]         write_activate,
  output logic [COUNT_W-1:0]      write_size,
  input  wire logic               write_strobe,
  input  wire logic [DATA_W-1:0]  write_data,
  input  wire xfer_cmd_t          rd_cmd,
  output logic                    read_error,
  output logic                    read_ready,
  input  wire logic               read_activate,
  output logic [COUNT_W-1:0]      read_size,
  output logic [DATA_W-1:0]       read_data,
  input  wire logic               read_strobe
);

  ram_wr_t            eng_wr;
  logic [ADDR_W-1:0]  eng_rd_addr;
  logic [DATA_W-1:0]  ram_rd_data;
  logic               wf_ready;
  logic               wf_activate;
  logic [COUNT_W-1:0] wf_count;
  logic [DATA_W-1:0]  wf_data;
  logic               wf_strobe;
  logic               wf_empty;
  logic [1:0]         rf_ready;
  logic [1:0]         rf_activate;
  logic [COUNT_W-1:0] rf_size;
  logic               rf_strobe;

  assign bram_data_out = ram_rd_data;

  // Both FIFOs stay cleared until the RAM fill is done
  pingpong_fifo write_fifo (
    .clk         (clk),
    .rst         (initializing),
    .wr_ready    (write_ready),
    .wr_activate (write_activate),
    .wr_size     (write_size),
    .wr_strobe   (write_strobe),
    .wr_data     (write_data),
    .rd_ready    (wf_ready),
    .rd_activate (wf_activate),
    .rd_count    (wf_count),
    .rd_data     (wf_data),
    .rd_strobe   (wf_strobe),
    .empty       (wf_empty)
  );

  stream_writer i_stream_writer (
    .clk           (clk),
    .rst           (rst),
    .cmd           (wr_cmd),
    .initializing  (initializing),
    .fifo_ready    (wf_ready),
    .fifo_activate (wf_activate),
    .fifo_count    (wf_count),
    .fifo_data     (wf_data),
    .fifo_strobe   (wf_strobe),
    .fifo_empty    (wf_empty),
    .ram_wr        (eng_wr),
    .finished      (write_finished),
    .seq_error     (write_error)
  );

  pattern_ram i_pattern_ram (
    .clk          (clk),
    .rst          (rst),
    .eng_wr       (eng_wr),
    .eng_rd_addr  (eng_rd_addr),
    .bram_en      (bram_en),
    .bram_we      (bram_we),
    .bram_address (bram_address),
    .bram_data_in (bram_data_in),
    .rd_data      (ram_rd_data),
    .initializing (initializing)
  );

  stream_reader i_stream_reader (
    .clk           (clk),
    .rst           (rst),
    .cmd           (rd_cmd),
    .initializing  (initializing),
    .fifo_ready    (rf_ready),
    .fifo_activate (rf_activate),
    .fifo_size     (rf_size),
    .fifo_strobe   (rf_strobe),
    .ram_rd_addr   (eng_rd_addr),
    .ram_rd_data   (ram_rd_data),
    .seq_error     (read_error)
  );

  pingpong_fifo read_fifo (
    .clk         (clk),
    .rst         (initializing),
    .wr_ready    (rf_ready),
    .wr_activate (rf_activate),
    .wr_size     (rf_size),
    .wr_strobe   (rf_strobe),
    .wr_data     (ram_rd_data),
    .rd_ready    (read_ready),
    .rd_activate (read_activate),
    .rd_count    (read_size),
    .rd_data     (read_data),
    .rd_strobe   (read_strobe),
    .empty       ()
  );

endmodule

`default_nettype wire

/* verif/tb_test_mem_dev.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_test_mem_dev
  import tmd_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic               clk = 1'b0;
  logic               rst;
  logic               bram_en;
  logic               bram_we;
  logic [ADDR_W-1:0]  bram_address;
  logic [DATA_W-1:0]  bram_data_in;
  logic [DATA_W-1:0]  bram_data_out;
  logic               initializing;
  xfer_cmd_t          wr_cmd;
  logic               write_finished;
  logic               write_error;
  logic [1:0]         write_ready;
  logic [1:0]         write_activate;
  logic [COUNT_W-1:0] write_size;
  logic               write_strobe;
  logic [DATA_W-1:0]  write_data;
  xfer_cmd_t          rd_cmd;
  logic               read_error;
  logic               read_ready;
  logic               read_activate;
  logic [COUNT_W-1:0] read_size;
  logic [DATA_W-1:0]  read_data;
  logic               read_strobe;

  // Reference copy of the RAM contents
  logic [DATA_W-1:0]  model [RAM_WORDS];
  logic [DATA_W-1:0]  stream_vals [$];
  int                 wr_err_cnt = 0;
  int                 rd_err_cnt = 0;

  test_mem_dev i_test_mem_dev (.*);

  always #5 clk = ~clk;

  // Error pulses counted mid-cycle
  always @(negedge clk) begin
    if (write_error === 1'b1) begin
      wr_err_cnt = wr_err_cnt + 1;
    end
    if (read_error === 1'b1) begin
      rd_err_cnt = rd_err_cnt + 1;
    end
  end

  task automatic step_clock();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else abort_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] a,
                                                  input logic inc, input logic dec);
    if (inc) begin
      return a + 1'b1;
    end
    return dec ? a - 1'b1 : a;
  endfunction

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bram_en      = 1'b1;
    bram_we      = 1'b1;
    bram_address = addr;
    bram_data_in = data;
    step_clock();
    bram_en = 1'b0;
    bram_we = 1'b0;
    model[addr] = data;
  endtask

  task automatic host_read_check(input logic [ADDR_W-1:0] addr);
    bram_en      = 1'b1;
    bram_we      = 1'b0;
    bram_address = addr;
    step_clock();
    bram_en = 1'b0;
    check_value("bram_data_out", bram_data_out, model[addr]);
  endtask

  // Producer side of the write FIFO that fills one bank at a time
  task automatic push_stream();
    int idx;
    int n;
    int tries;
    idx = 0;
    while (idx < stream_vals.size()) begin
      tries = 0;
      while (write_ready == 2'b00) begin
        if (tries == WAIT_LIMIT) begin
          abort_run("timeout waiting for write_ready");
        end
        tries++;
        step_clock();
      end
      // Both banks are empty when a stream starts
      if (idx == 0) begin
        check_value("write_ready", 32'(write_ready), 32'h3);
      end
      check_value("write_size", 32'(write_size), 32'(FIFO_WORDS));
      write_activate = write_ready[0] ? 2'b01 : 2'b10;
      n = 0;
      while (idx < stream_vals.size() && n < int'(FIFO_WORDS)) begin
        write_strobe = 1'b1;
        write_data   = stream_vals[idx];
        step_clock();
        idx++;
        n++;
      end
      write_strobe   = 1'b0;
      write_activate = 2'b00;
      step_clock();
    end
  endtask

  task automatic run_write(input logic [ADDR_W-1:0] addr, input int count, input logic inc,
                           input logic dec, input logic flush, input logic [DATA_W-1:0] start,
                           input int gap, input int err);
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] v;
    int base;
    int tries;
    stream_vals.delete();
    a = addr;
    for (int i = 0; i < count; i++) begin
      v = start + DATA_W'(i);
      // Gap drops one value from the sequence
      if (gap != 0 && i >= gap) begin
        v = v + 1'b1;
      end
      stream_vals.push_back(v);
      model[a] = v;
      a = next_addr(a, inc, dec);
    end
    base = wr_err_cnt;
    wr_cmd = '{enable: 1'b1, addr: addr, count: COUNT_W'(count), inc: inc, dec: dec,
               flush: flush};
    step_clock();
    push_stream();
    tries = 0;
    while (write_finished !== 1'b1) begin
      if (tries == WAIT_LIMIT) begin
        abort_run("timeout waiting for write_finished");
      end
      tries++;
      step_clock();
    end
    repeat (2) step_clock();
    check_value("write_error", 32'(wr_err_cnt != base), 32'(err));
    wr_cmd = '0;
    repeat (2) step_clock();
  endtask

  task automatic run_read(input logic [ADDR_W-1:0] addr, input int count, input logic inc,
                          input logic dec, input logic flush, input int err);
    logic [ADDR_W-1:0] a;
    int base;
    int tries;
    int got_words;
    int n;
    base = rd_err_cnt;
    rd_cmd = '{enable: 1'b1, addr: addr, count: COUNT_W'(count), inc: inc, dec: dec,
               flush: flush};
    a = addr;
    got_words = 0;
    while (got_words < count) begin
      tries = 0;
      while (read_ready !== 1'b1) begin
        if (tries == WAIT_LIMIT) begin
          abort_run("timeout waiting for read_ready");
        end
        tries++;
        step_clock();
      end
      // Full bank unless the transfer ends first
      n = (count - got_words < int'(FIFO_WORDS)) ? count - got_words : int'(FIFO_WORDS);
      check_value("read_size", 32'(read_size), 32'(n));
      read_activate = 1'b1;
      for (int k = 0; k < n; k++) begin
        read_strobe = 1'b1;
        check_value("read_data", read_data, model[a]);
        a = next_addr(a, inc, dec);
        step_clock();
      end
      read_strobe   = 1'b0;
      read_activate = 1'b0;
      got_words += n;
      step_clock();
    end
    repeat (2) step_clock();
    check_value("read_error", 32'(rd_err_cnt != base), 32'(err));
    rd_cmd = '0;
    repeat (2) step_clock();
  endtask

  initial begin
    int fd;
    int n;
    int recs;
    int fill_cycles;
    int count;
    int gap;
    int err;
    logic [7:0] op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] start;
    logic inc;
    logic dec;
    logic flush;
    string line;

    rst            = 1'b1;
    bram_en        = 1'b0;
    bram_we        = 1'b0;
    bram_address   = '0;
    bram_data_in   = '0;
    wr_cmd         = '0;
    rd_cmd         = '0;
    write_activate = 2'b00;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_activate  = 1'b0;
    read_strobe    = 1'b0;
    for (int i = 0; i < int'(RAM_WORDS); i++) begin
      model[ADDR_W'(i)] = DATA_W'(i);
    end

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("initializing", 32'(initializing), 32'd1);
    check_value("write_finished", 32'(write_finished), 32'd0);
    check_value("read_ready", 32'(read_ready), 32'd0);

    fill_cycles = 0;
    while (initializing === 1'b1) begin
      if (fill_cycles == WAIT_LIMIT) begin
        abort_run("timeout waiting for the RAM fill to end");
      end
      check_value("write_ready", 32'(write_ready), 32'd0);
      fill_cycles++;
      step_clock();
    end
    check_value("initializing cycles", 32'(fill_cycles), 32'(RAM_WORDS));

    fd = $fopen("verif/test_mem_dev_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the golden file");
    end
    recs = 0;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %d %d %d %d %h %d %d",
                  op, addr, count, inc, dec, flush, start, gap, err);
      if (n <= 0) begin
        continue;
      end
      if (n != 9) begin
        abort_run("malformed record in the golden file");
      end
      recs++;
      case (op)
        "R": begin
          for (int i = 0; i < count; i++) begin
            host_read_check(ADDR_W'(addr + i));
          end
        end
        "W": begin
          for (int i = 0; i < count; i++) begin
            host_write(ADDR_W'(addr + i), start + DATA_W'(i));
          end
        end
        "S": run_write(addr, count, inc, dec, flush, start, gap, err);
        "T": run_read(addr, count, inc, dec, flush, err);
        default: abort_run("unknown opcode in the golden file");
      endcase
    end
    $fclose(fd);
    if (recs == 0) begin
      abort_run("golden file holds no records");
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/test_mem_dev_golden.txt */
# op addr count inc dec flush start gap err  (addr and start in hex, others decimal)
# R host read, W host write, S write stream, T read stream; gap skips one value from that word on
R 00 1 0 0 0 0 0 0
R 01 1 0 0 0 0 0 0
R 7f 1 0 0 0 0 0 0
R ff 1 0 0 0 0 0 0
W 90 1 0 0 0 deadbeef 0 0
R 90 1 0 0 0 0 0 0
W 40 4 0 0 0 1000 0 0
R 3f 6 0 0 0 0 0 0
S 10 32 1 0 0 28 0 0
R 10 32 0 0 0 0 0 0
T fa 20 1 0 0 0 0 0
S 60 16 1 0 0 64 5 1
S 70 16 1 0 1 64 5 0
R 60 32 0 0 0 0 0 0
T 8c 8 1 0 0 0 0 1
T 2f 10 0 1 1 0 0 0
T 2f 10 0 1 0 0 0 1
S c0 8 0 1 0 c8 0 0
R b9 8 0 0 0 0 0 0
T 00 12 1 0 0 0 0 0
T 10 32 1 0 0 0 0 0

/* src.f */
source/tmd_pkg.sv
source/pingpong_fifo.sv
source/pattern_ram.sv
source/stream_writer.sv
source/stream_reader.sv
source/test_mem_dev.sv
verif/tb_test_mem_dev.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_test_mem_dev
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
